//--- run_sim.sh
#!/bin/sh
# compile and run the core top testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_core_top -f sources.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_core_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
  exit 1
fi
exit 0

//--- sources.f
+incdir+verilog
verilog/core_pkg.sv
verilog/bridge_settings_regs.sv
verilog/datatable_writer.sv
verilog/video_sync_shaper.sv
verilog/core_top.sv
tb/core_top_checker.sv
tb/tb_core_top.sv

//--- tb/core_top_checker.sv
//////////////////////////////
// data table handshake assertions,
// bound into datatable_writer
//////////////////////////////

`default_nettype none

`include "core_config.svh"

module core_top_checker (
  input logic                         clk_74a,
  input logic                         pll_core_locked,
  input logic                         datatable_req,
  input logic                         datatable_ack,
  input logic [`DATATABLE_ADDR_W-1:0] datatable_addr,
  input logic [`BRIDGE_DATA_W-1:0]    datatable_data
);

  timeunit 1ns;
  timeprecision 1ps;

  // req held until the host answers
  req_held: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    datatable_req && !datatable_ack |=> datatable_req)
    else $error("datatable_req dropped before datatable_ack");

  // entry stays put for the whole request
  entry_stable: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    datatable_req && $past(datatable_req) |-> $stable(datatable_data) && $stable(datatable_addr))
    else $error("datatable entry changed while datatable_req was high");

  // a new request waits until ack is gone
  no_early_req: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    $rose(datatable_req) |-> !$past(datatable_ack))
    else $error("datatable_req rose while datatable_ack was still high");

endmodule

`default_nettype wire

//--- tb/tb_core_top.sv
//////////////////////////////
// core top testbench with settings, reset
// pulse, data table host and video frames
//////////////////////////////

`default_nettype none

`include "core_config.svh"

module tb_core_top import core_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 64;
  localparam int FRAME = 32;
  // 12 mapped registers then 4 addresses that must read zero
  localparam logic [31:0] TEST_ADDR [16] = '{
    32'h000, 32'h004, 32'h008, 32'h00C, 32'h010, 32'h100, 32'h110, 32'h200,
    32'h204, 32'h208, 32'h20C, 32'h300, 32'h014, 32'h104, 32'h400, 32'h1208
  };

  logic                         clk_74a;
  logic                         pll_core_locked;
  logic [`BRIDGE_ADDR_W-1:0]    bridge_addr;
  logic                         bridge_wr;
  logic [`BRIDGE_DATA_W-1:0]    bridge_wr_data;
  logic                         bridge_rd;
  logic [`BRIDGE_DATA_W-1:0]    bridge_rd_data;
  logic [1:0]                   cart_download;
  logic [1:0]                   bios_download;
  logic                         save_download;
  system_sel_t                  configured_system;
  logic                         use_cpu_turbo;
  logic                         use_triple_buffer;
  logic [1:0]                   configured_flickerblend;
  logic                         use_flip_horizontal;
  logic                         use_fastforward_sound;
  logic                         external_reset;
  logic [`SAVE_SIZE_W-1:0]      save_size;
  logic                         has_rtc;
  logic                         datatable_ack;
  logic                         datatable_req;
  logic [`DATATABLE_ADDR_W-1:0] datatable_addr;
  logic [`BRIDGE_DATA_W-1:0]    datatable_data;
  logic                         h_blank;
  logic                         v_blank;
  logic                         hsync_in;
  logic                         vsync_in;
  logic [`RGB_W-1:0]            rgb_in;
  logic                         is_vertical;
  logic [`RGB_W-1:0]            video_rgb;
  logic                         video_de;
  logic                         video_hs;
  logic                         video_vs;

  logic [31:0]       lfsr_state;
  logic [31:0]       wdata [16];
  logic              frame_de [FRAME];
  logic              frame_hs [FRAME];
  logic              frame_vs [FRAME];
  logic [`RGB_W-1:0] frame_rgb [FRAME];
  int                checks;
  int                errors;

  core_top dut_i (.*);

  bind datatable_writer core_top_checker checker_i (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .datatable_req  (datatable_req),
    .datatable_ack  (datatable_ack),
    .datatable_addr (datatable_addr),
    .datatable_data (datatable_data)
  );

  initial begin
    clk_74a = 1'b0;
    forever #10 clk_74a = ~clk_74a;
  end

  //////////////////////////////
  // random bits and reference model
  //////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic logic [31:0] ref_readback(input logic [31:0] addr,
                                               input logic [31:0] data,
                                               input logic rst_on);
    case (addr)
      32'h050:                   ref_readback = {31'b0, rst_on};
      32'h100, 32'h204, 32'h208: ref_readback = {30'b0, data[1:0]};
      32'h000, 32'h004, 32'h008, 32'h00C, 32'h010, 32'h110, 32'h200, 32'h20C, 32'h300:
        ref_readback = {31'b0, data[0]};
      default:                   ref_readback = '0;
    endcase
  endfunction

  function automatic logic [31:0] ref_entry(input logic [`SAVE_SIZE_W-1:0] size,
                                            input logic rtc);
    ref_entry = 32'(size) * 32'(`SAVE_BLOCK_BYTES) + (rtc ? 32'(`RTC_EXTRA_BYTES) : 32'd0);
  endfunction

  function automatic logic [`RGB_W-1:0] ref_slot(input logic [1:0] orient,
                                                 input logic vert);
    ref_slot = '0;
    case (orient)
      2'd0:    ref_slot[`SLOT_ORIENT_BIT] = vert;
      2'd2:    ref_slot[`SLOT_ORIENT_BIT] = 1'b1;
      default: ref_slot[`SLOT_ORIENT_BIT] = 1'b0;
    endcase
  endfunction

  // cycles before the frame count as idle
  function automatic logic de_at(input int i);
    de_at = (i < 0) ? 1'b0 : frame_de[i[4:0]];
  endfunction

  function automatic logic hs_at(input int i);
    hs_at = (i < 0) ? 1'b0 : frame_hs[i[4:0]];
  endfunction

  function automatic logic vs_at(input int i);
    vs_at = (i < 0) ? 1'b0 : frame_vs[i[4:0]];
  endfunction

  //////////////////////////////
  // compare and bus tasks
  //////////////////////////////

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // top level setting output against the value written to its register
  task automatic check_setting(input string what, input logic [31:0] got, input int idx);
    compare(what, got, ref_readback(TEST_ADDR[idx[3:0]], wdata[idx[3:0]], 1'b0));
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("%s: %s (%0d errors)", name, (errors == err_before) ? "pass" : "fail",
             errors - err_before);
  endtask

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clk_74a);
    bridge_addr = addr;
    bridge_wr_data = data;
    bridge_wr = 1'b1;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
  endtask

  task automatic bridge_read(input logic [31:0] addr, output logic [31:0] data);
    @(negedge clk_74a);
    bridge_addr = addr;
    bridge_rd = 1'b1;
    @(negedge clk_74a);
    data = bridge_rd_data;
    bridge_rd = 1'b0;
  endtask

  task automatic wait_req_level(input logic level, input string what);
    int n;
    n = 0;
    while (datatable_req !== level && n < WAIT_LIMIT) begin
      @(negedge clk_74a);
      n++;
    end
    if (datatable_req !== level) begin
      errors++;
      $display("timeout: %s", what);
    end
  endtask

  // host side of one transfer with a random ack delay
  task automatic serve_datatable(input logic [31:0] exp_word);
    logic [31:0] delay;
    wait_req_level(1'b1, "datatable_req never rose");
    compare("datatable_addr", 32'(datatable_addr), 32'(`DATATABLE_SAVE_ADDR));
    compare("datatable_data", datatable_data, exp_word);
    take_bits(3, delay);
    repeat (delay) @(negedge clk_74a);
    datatable_ack = 1'b1;
    wait_req_level(1'b0, "datatable_req never dropped after ack");
    datatable_ack = 1'b0;
  endtask

  task automatic expect_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk_74a);
      compare("datatable_req without change", 32'(datatable_req), 32'd0);
    end
  endtask

  task automatic run_frame(input logic [1:0] orient, input logic vert);
    logic [31:0]       r;
    logic [`RGB_W-1:0] exp_rgb;
    int                e;
    for (int c = 0; c <= FRAME; c++) begin
      @(negedge clk_74a);
      // outputs of the edge that sampled cycle c-1
      if (c > 0) begin
        e = c - 1;
        if (de_at(e)) exp_rgb = frame_rgb[e[4:0]];
        else if (de_at(e - 1)) exp_rgb = ref_slot(orient, vert);
        else exp_rgb = '0;
        compare("video_de", 32'(video_de), 32'(de_at(e)));
        compare("video_rgb", 32'(video_rgb), 32'(exp_rgb));
        compare("video_vs", 32'(video_vs), 32'(vs_at(e) && !vs_at(e - 1)));
        compare("video_hs", 32'(video_hs), 32'(hs_at(e - 6) && !hs_at(e - 7)));
      end
      if (c < FRAME) begin
        take_bits(`RGB_W, r);
        v_blank = (c < 2) || (c >= 26);
        h_blank = (c >= 12) && (c < 16);
        hsync_in = (c == 13) || (c == 14);
        vsync_in = (c == 27) || (c == 28);
        rgb_in = r[`RGB_W-1:0];
        frame_de[c[4:0]] = !h_blank && !v_blank;
        frame_hs[c[4:0]] = hsync_in;
        frame_vs[c[4:0]] = vsync_in;
        frame_rgb[c[4:0]] = rgb_in;
      end else begin
        h_blank = 1'b1;
        v_blank = 1'b1;
        hsync_in = 1'b0;
        vsync_in = 1'b0;
        rgb_in = '0;
      end
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    logic [31:0]             r;
    logic [31:0]             rd;
    logic [31:0]             old_word;
    int                      err_before;
    int                      high_cycles;

    lfsr_state = 32'h157f744a;
    checks = 0;
    errors = 0;
    pll_core_locked = 1'b0;
    bridge_addr = '0;
    bridge_wr = 1'b0;
    bridge_wr_data = '0;
    bridge_rd = 1'b0;
    save_size = 12'd64;
    has_rtc = 1'b0;
    datatable_ack = 1'b0;
    h_blank = 1'b1;
    v_blank = 1'b1;
    hsync_in = 1'b0;
    vsync_in = 1'b0;
    rgb_in = '0;
    is_vertical = 1'b0;
    repeat (5) @(posedge clk_74a);
    @(negedge clk_74a);
    pll_core_locked = 1'b1;

    err_before = errors;
    for (int i = 0; i < 16; i++) begin
      take_bits(32, r);
      wdata[i[3:0]] = r;
      bridge_write(TEST_ADDR[i[3:0]], r);
    end
    for (int i = 0; i < 16; i++) begin
      bridge_read(TEST_ADDR[i[3:0]], rd);
      compare("bridge_rd_data", rd, ref_readback(TEST_ADDR[i[3:0]], wdata[i[3:0]], 1'b0));
    end
    check_setting("save_download", 32'(save_download), 4);
    check_setting("configured_system", 32'(configured_system), 5);
    check_setting("use_cpu_turbo", 32'(use_cpu_turbo), 6);
    check_setting("use_triple_buffer", 32'(use_triple_buffer), 7);
    check_setting("configured_flickerblend", 32'(configured_flickerblend), 8);
    check_setting("use_flip_horizontal", 32'(use_flip_horizontal), 10);
    check_setting("use_fastforward_sound", 32'(use_fastforward_sound), 11);
    report_test("settings readback", err_before);

    err_before = errors;
    for (int i = 0; i < 4; i++) begin
      bridge_write(REG_CART_DOWNLOAD, 32'(i[0]));
      bridge_write(REG_COLOR_CART, 32'(i[1]));
      bridge_write(REG_MONO_BIOS, 32'(i[1]));
      bridge_write(REG_COLOR_BIOS, 32'(i[0]));
      compare("cart_download", 32'(cart_download), 32'({i[1] & i[0], ~i[1] & i[0]}));
      compare("bios_download", 32'(bios_download), 32'({i[0], i[1]}));
    end
    report_test("download outputs", err_before);

    err_before = errors;
    bridge_write(REG_RESET, 32'd1);
    high_cycles = 0;
    while (external_reset && high_cycles < 2 * `RESET_DELAY_CYCLES) begin
      compare("reset readback", bridge_rd_data, 32'd1);
      high_cycles++;
      @(negedge clk_74a);
    end
    if (external_reset) begin
      errors++;
      $display("timeout: external_reset never returned low");
    end
    compare("reset readback after pulse", bridge_rd_data, 32'd0);
    compare("external_reset length", 32'(high_cycles), 32'(`RESET_DELAY_CYCLES));
    report_test("reset pulse", err_before);

    err_before = errors;
    serve_datatable(ref_entry(save_size, has_rtc));
    expect_idle(16);
    take_bits(12, r);
    save_size = save_size + (r[11:0] | 12'd1);
    serve_datatable(ref_entry(save_size, has_rtc));
    has_rtc = 1'b1;
    serve_datatable(ref_entry(save_size, has_rtc));
    // change while a request is pending
    take_bits(12, r);
    save_size = save_size + (r[11:0] | 12'd1);
    has_rtc = 1'b0;
    wait_req_level(1'b1, "datatable_req never rose");
    old_word = ref_entry(save_size, 1'b0);
    take_bits(12, r);
    save_size = save_size + (r[11:0] | 12'd1);
    serve_datatable(old_word);
    serve_datatable(ref_entry(save_size, has_rtc));
    expect_idle(16);
    report_test("data table transfers", err_before);

    err_before = errors;
    for (int o = 0; o < 4; o++) begin
      for (int v = 0; v < 2; v++) begin
        bridge_write(REG_ORIENTATION, 32'(o[1:0]));
        is_vertical = v[0];
        run_frame(o[1:0], v[0]);
      end
    end
    report_test("video shaping", err_before);

    $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/bridge_settings_regs.sv
//////////////////////////////
// bridge settings registers, delayed
// external reset and readback mux
//////////////////////////////

`default_nettype none

`include "core_config.svh"

module bridge_settings_regs import core_pkg::*; (
  input  logic                      clk_74a,
  input  logic                      pll_core_locked,
  input  logic [`BRIDGE_ADDR_W-1:0] bridge_addr,
  input  logic                      bridge_wr,
  input  logic [`BRIDGE_DATA_W-1:0] bridge_wr_data,
  output logic [`BRIDGE_DATA_W-1:0] bridge_rd_data,
  output logic [1:0]                cart_download,
  output logic [1:0]                bios_download,
  output logic                      save_download,
  output system_sel_t               configured_system,
  output logic                      use_cpu_turbo,
  output logic                      use_triple_buffer,
  output logic [1:0]                configured_flickerblend,
  output orientation_t              configured_orientation,
  output logic                      use_flip_horizontal,
  output logic                      use_fastforward_sound,
  output logic                      external_reset
);

  localparam int RST_CNT_W = $clog2(`RESET_DELAY_CYCLES + 1);
  localparam logic [RST_CNT_W-1:0] RST_LOAD = `RESET_DELAY_CYCLES;

  logic                 cart_dl_flag;
  logic                 is_color_cart;
  logic [RST_CNT_W-1:0] reset_count;

  //////////////////////////////
  // register writes
  //////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      cart_dl_flag            <= 1'b0;
      is_color_cart           <= 1'b0;
      bios_download           <= 2'b00;
      save_download           <= 1'b0;
      configured_system       <= SYSTEM_AUTO;
      use_cpu_turbo           <= 1'b0;
      use_triple_buffer       <= 1'b0;
      configured_flickerblend <= 2'b00;
      configured_orientation  <= ORIENT_AUTO;
      use_flip_horizontal     <= 1'b0;
      use_fastforward_sound   <= 1'b0;
      reset_count             <= '0;
    end else begin
      if (reset_count != '0) begin
        reset_count <= reset_count - 1'b1;
      end

      if (bridge_wr) begin
        case (bridge_addr)
          REG_CART_DOWNLOAD: cart_dl_flag            <= bridge_wr_data[0];
          REG_COLOR_CART:    is_color_cart           <= bridge_wr_data[0];
          REG_MONO_BIOS:     bios_download[0]        <= bridge_wr_data[0];
          REG_COLOR_BIOS:    bios_download[1]        <= bridge_wr_data[0];
          REG_SAVE_DOWNLOAD: save_download           <= bridge_wr_data[0];
          // restarts the count if a pulse is already running
          REG_RESET:         reset_count             <= RST_LOAD;
          REG_SYSTEM:        configured_system       <= system_sel_t'(bridge_wr_data[1:0]);
          REG_CPU_TURBO:     use_cpu_turbo           <= bridge_wr_data[0];
          REG_TRIPLE_BUFFER: use_triple_buffer       <= bridge_wr_data[0];
          REG_FLICKER_BLEND: configured_flickerblend <= bridge_wr_data[1:0];
          REG_ORIENTATION:   configured_orientation  <= orientation_t'(bridge_wr_data[1:0]);
          REG_FLIP_HORIZ:    use_flip_horizontal     <= bridge_wr_data[0];
          REG_FF_SOUND:      use_fastforward_sound   <= bridge_wr_data[0];
          default: ;
        endcase
      end
    end
  end

  assign external_reset = (reset_count != '0);

  // colour cart in bit 1, mono cart in bit 0
  assign cart_download = {is_color_cart & cart_dl_flag, ~is_color_cart & cart_dl_flag};

  //////////////////////////////
  // readback
  //////////////////////////////

  always_comb begin
    bridge_rd_data = '0;
    case (bridge_addr)
      REG_CART_DOWNLOAD: bridge_rd_data[0]   = cart_dl_flag;
      REG_COLOR_CART:    bridge_rd_data[0]   = is_color_cart;
      REG_MONO_BIOS:     bridge_rd_data[0]   = bios_download[0];
      REG_COLOR_BIOS:    bridge_rd_data[0]   = bios_download[1];
      REG_SAVE_DOWNLOAD: bridge_rd_data[0]   = save_download;
      REG_RESET:         bridge_rd_data[0]   = external_reset;
      REG_SYSTEM:        bridge_rd_data[1:0] = configured_system;
      REG_CPU_TURBO:     bridge_rd_data[0]   = use_cpu_turbo;
      REG_TRIPLE_BUFFER: bridge_rd_data[0]   = use_triple_buffer;
      REG_FLICKER_BLEND: bridge_rd_data[1:0] = configured_flickerblend;
      REG_ORIENTATION:   bridge_rd_data[1:0] = configured_orientation;
      REG_FLIP_HORIZ:    bridge_rd_data[0]   = use_flip_horizontal;
      REG_FF_SOUND:      bridge_rd_data[0]   = use_fastforward_sound;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/core_config.svh
//////////////////////////////
// widths, register addresses and timing
// constants shared by the core top RTL
//////////////////////////////

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// bridge bus
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32

// video
`define RGB_W 24
`define HS_DELAY_LOAD 7
`define SLOT_ORIENT_BIT 13

// save size entry, save_size counts 512 byte blocks
`define SAVE_SIZE_W 12
`define SAVE_BLOCK_BYTES 512
`define RTC_EXTRA_BYTES 12

// data table, size word of data slot index 3
`define DATATABLE_ADDR_W 10
`define DATATABLE_SAVE_ADDR 7

// external reset length, kept short for simulation
`define RESET_DELAY_CYCLES 256

`endif

//--- verilog/core_pkg.sv
//////////////////////////////
// bridge register map, system and orientation
// selections, data table handshake states
//////////////////////////////

`default_nettype none

`include "core_config.svh"

package core_pkg;

  // bridge register addresses, decoded as opcodes
  typedef enum logic [`BRIDGE_ADDR_W-1:0] {
    REG_CART_DOWNLOAD  = 32'h000,
    REG_COLOR_CART     = 32'h004,
    REG_MONO_BIOS      = 32'h008,
    REG_COLOR_BIOS     = 32'h00C,
    REG_SAVE_DOWNLOAD  = 32'h010,
    REG_RESET          = 32'h050,
    REG_SYSTEM         = 32'h100,
    REG_CPU_TURBO      = 32'h110,
    REG_TRIPLE_BUFFER  = 32'h200,
    REG_FLICKER_BLEND  = 32'h204,
    REG_ORIENTATION    = 32'h208,
    REG_FLIP_HORIZ     = 32'h20C,
    REG_FF_SOUND       = 32'h300
  } bridge_reg_t;

  typedef enum logic [1:0] {SYSTEM_AUTO, SYSTEM_MONO, SYSTEM_COLOR} system_sel_t;

  typedef enum logic [1:0] {
    ORIENT_AUTO       = 2'd0,
    ORIENT_HORIZONTAL = 2'd1,
    ORIENT_VERTICAL   = 2'd2
  } orientation_t;

  typedef enum logic [1:0] {DT_IDLE, DT_REQ, DT_RELEASE} dt_state_t;

endpackage

`default_nettype wire

//--- verilog/core_top.sv
//////////////////////////////
// core top, bridge settings, data table
// writer and video shaping
//////////////////////////////

`default_nettype none

`include "core_config.svh"

module core_top import core_pkg::*; (
  input  logic                         clk_74a,
  input  logic                         pll_core_locked,
  // bridge bus
  input  logic [`BRIDGE_ADDR_W-1:0]    bridge_addr,
  input  logic                         bridge_wr,
  input  logic [`BRIDGE_DATA_W-1:0]    bridge_wr_data,
  // read is combinational, strobe not needed
  input  logic                         bridge_rd,
  output logic [`BRIDGE_DATA_W-1:0]    bridge_rd_data,
  // settings
  output logic [1:0]                   cart_download,
  output logic [1:0]                   bios_download,
  output logic                         save_download,
  output system_sel_t                  configured_system,
  output logic                         use_cpu_turbo,
  output logic                         use_triple_buffer,
  output logic [1:0]                   configured_flickerblend,
  output logic                         use_flip_horizontal,
  output logic                         use_fastforward_sound,
  output logic                         external_reset,
  // data table
  input  logic [`SAVE_SIZE_W-1:0]      save_size,
  input  logic                         has_rtc,
  input  logic                         datatable_ack,
  output logic                         datatable_req,
  output logic [`DATATABLE_ADDR_W-1:0] datatable_addr,
  output logic [`BRIDGE_DATA_W-1:0]    datatable_data,
  // video
  input  logic                         h_blank,
  input  logic                         v_blank,
  input  logic                         hsync_in,
  input  logic                         vsync_in,
  input  logic [`RGB_W-1:0]            rgb_in,
  input  logic                         is_vertical,
  output logic [`RGB_W-1:0]            video_rgb,
  output logic                         video_de,
  output logic                         video_hs,
  output logic                         video_vs
);

  orientation_t configured_orientation;

  bridge_settings_regs settings_i (
    .clk_74a                (clk_74a),
    .pll_core_locked        (pll_core_locked),
    .bridge_addr            (bridge_addr),
    .bridge_wr              (bridge_wr),
    .bridge_wr_data         (bridge_wr_data),
    .bridge_rd_data         (bridge_rd_data),
    .cart_download          (cart_download),
    .bios_download          (bios_download),
    .save_download          (save_download),
    .configured_system      (configured_system),
    .use_cpu_turbo          (use_cpu_turbo),
    .use_triple_buffer      (use_triple_buffer),
    .configured_flickerblend(configured_flickerblend),
    .configured_orientation (configured_orientation),
    .use_flip_horizontal    (use_flip_horizontal),
    .use_fastforward_sound  (use_fastforward_sound),
    .external_reset         (external_reset)
  );

  datatable_writer datatable_i (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .save_size      (save_size),
    .has_rtc        (has_rtc),
    .datatable_ack  (datatable_ack),
    .datatable_req  (datatable_req),
    .datatable_addr (datatable_addr),
    .datatable_data (datatable_data)
  );

  video_sync_shaper video_i (
    .clk_74a               (clk_74a),
    .pll_core_locked       (pll_core_locked),
    .h_blank               (h_blank),
    .v_blank               (v_blank),
    .hsync_in              (hsync_in),
    .vsync_in              (vsync_in),
    .rgb_in                (rgb_in),
    .is_vertical           (is_vertical),
    .configured_orientation(configured_orientation),
    .video_rgb             (video_rgb),
    .video_de              (video_de),
    .video_hs              (video_hs),
    .video_vs              (video_vs)
  );

endmodule

`default_nettype wire

//--- verilog/datatable_writer.sv
//////////////////////////////
// save size data table entry, sent to
// the host by four-phase req/ack
//////////////////////////////

`default_nettype none

`include "core_config.svh"

module datatable_writer import core_pkg::*; (
  input  logic                         clk_74a,
  input  logic                         pll_core_locked,
  input  logic [`SAVE_SIZE_W-1:0]      save_size,
  input  logic                         has_rtc,
  input  logic                         datatable_ack,
  output logic                         datatable_req,
  output logic [`DATATABLE_ADDR_W-1:0] datatable_addr,
  output logic [`BRIDGE_DATA_W-1:0]    datatable_data
);

  dt_state_t                 state;
  logic                      sent_valid;
  logic [`BRIDGE_DATA_W-1:0] last_sent;
  logic [`BRIDGE_DATA_W-1:0] size_entry;
  logic                      need_send;
  logic                      start_xfer;

  // bytes of save ram, rtc adds its own words at the end
  assign size_entry = `BRIDGE_DATA_W'(save_size) * `BRIDGE_DATA_W'(`SAVE_BLOCK_BYTES)
                    + (has_rtc ? `BRIDGE_DATA_W'(`RTC_EXTRA_BYTES) : '0);

  assign need_send  = !sent_valid || (size_entry != last_sent);
  assign start_xfer = (state == DT_IDLE) && need_send && !datatable_ack;

  assign datatable_addr = `DATATABLE_ADDR_W'(`DATATABLE_SAVE_ADDR);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state         <= DT_IDLE;
      datatable_req <= 1'b0;
      sent_valid    <= 1'b0;
    end else begin
      case (state)
        DT_IDLE: if (start_xfer) begin
          datatable_req <= 1'b1;
          state         <= DT_REQ;
        end
        DT_REQ: if (datatable_ack) begin
          datatable_req <= 1'b0;
          sent_valid    <= 1'b1;
          state         <= DT_RELEASE;
        end
        // wait for the host to drop ack
        DT_RELEASE: if (!datatable_ack) state <= DT_IDLE;
        default: state <= DT_IDLE;
      endcase
    end
  end

  // word held stable for the whole transfer
  always_ff @(posedge clk_74a) begin
    if (start_xfer) datatable_data <= size_entry;
    if (state == DT_REQ && datatable_ack) last_sent <= datatable_data;
  end

endmodule

`default_nettype wire

//--- verilog/video_sync_shaper.sv
//////////////////////////////
// registered video to the scaler with
// de, vs and delayed hs pulses and slot word
//////////////////////////////

`default_nettype none

`include "core_config.svh"

module video_sync_shaper import core_pkg::*; (
  input  logic              clk_74a,
  input  logic              pll_core_locked,
  input  logic              h_blank,
  input  logic              v_blank,
  input  logic              hsync_in,
  input  logic              vsync_in,
  input  logic [`RGB_W-1:0] rgb_in,
  input  logic              is_vertical,
  input  orientation_t      configured_orientation,
  output logic [`RGB_W-1:0] video_rgb,
  output logic              video_de,
  output logic              video_hs,
  output logic              video_vs
);

  localparam int HS_CNT_W = $clog2(`HS_DELAY_LOAD + 1);
  localparam logic [HS_CNT_W-1:0] HS_LOAD = `HS_DELAY_LOAD;
  // counter value seen at the sixth edge after the load
  localparam logic [HS_CNT_W-1:0] HS_FIRE = HS_LOAD - 3'd5;

  logic                hs_prev;
  logic                vs_prev;
  logic                de_prev;
  logic [HS_CNT_W-1:0] hs_delay;
  logic                de;
  logic                orient_vertical;
  logic [`RGB_W-1:0]   slot_rgb;

  assign de = ~(h_blank | v_blank);

  always_comb begin
    case (configured_orientation)
      ORIENT_AUTO:     orient_vertical = is_vertical;
      ORIENT_VERTICAL: orient_vertical = 1'b1;
      default:         orient_vertical = 1'b0;
    endcase
  end

  // scaler picks the vertical slot from this bit
  always_comb begin
    slot_rgb                   = '0;
    slot_rgb[`SLOT_ORIENT_BIT] = orient_vertical;
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_rgb <= '0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      de_prev   <= 1'b0;
      hs_delay  <= '0;
    end else begin
      video_de <= de;
      if (de) video_rgb <= rgb_in;
      else if (de_prev) video_rgb <= slot_rgb;
      else video_rgb <= '0;

      // hsync held back so it never lands on the vsync pulse
      if (!hs_prev && hsync_in) hs_delay <= HS_LOAD;
      else if (hs_delay != '0) hs_delay <= hs_delay - 1'b1;
      video_hs <= (hs_delay == HS_FIRE);

      video_vs <= !vs_prev && vsync_in;

      hs_prev <= hsync_in;
      vs_prev <= vsync_in;
      de_prev <= de;
    end
  end

endmodule

`default_nettype wire
